/* design/udp_fields_pkg.sv */
package udp_fields_pkg;

    // IPv4 address as carried in the header, network byte order
    typedef logic [31:0] ip_addr_t;

    // UDP source or destination port
    typedef logic [15:0] udp_port_t;

    // UDP length, header plus payload in bytes
    typedef logic [15:0] udp_len_t;

    // TTL given to every echoed packet by the IP stage
    localparam logic [7:0] REPLY_TTL = 8'd64;

endpackage

/* design/stream_pkg.sv */
package stream_pkg;

    // Payload bytes carried per beat
    localparam int DATA_BYTES = 8;

    // One beat of payload data
    typedef logic [DATA_BYTES*8-1:0] beat_data_t;

    // One keep bit per data byte
    typedef logic [DATA_BYTES-1:0] beat_keep_t;

    // LED field, low bits of the first payload byte
    typedef logic [2:0] led_t;

endpackage

/* design/udp_echo_ctrl.sv */
`timescale 1ns/1ps

module udp_echo_ctrl #(
    parameter udp_fields_pkg::udp_port_t ECHO_PORT = 16'd1234
) (
    input  logic                      clk,
    input  logic                      rst,

    // Incoming header handshake, only the port is needed here
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_fields_pkg::udp_port_t rx_dst_port,

    // Reply header queue write side
    output logic                      hdr_push,
    input  logic                      hdr_full,

    // Incoming payload handshake
    input  logic                      rx_pl_valid,
    output logic                      rx_pl_ready,
    input  logic                      rx_pl_last,

    // Payload FIFO write side
    output logic                      pl_push,
    input  logic                      pl_full
);

    typedef enum logic [1:0] {
        IDLE,
        PASS,
        DROP
    } state_t;

    state_t state;
    state_t state_next;

    logic port_match;
    logic hdr_accept;
    logic pl_accept;

    assign port_match = (rx_dst_port == ECHO_PORT);

    // Non-matching headers never wait, matching ones need a free queue slot
    assign rx_hdr_ready = (state == IDLE) && (!port_match || !hdr_full);
    assign hdr_accept   = rx_hdr_valid && rx_hdr_ready;
    assign hdr_push     = hdr_accept && port_match;

    // Payload is either written to the FIFO or sunk without storage
    always_comb begin
        case (state)
            PASS:    rx_pl_ready = !pl_full;
            DROP:    rx_pl_ready = 1'b1;
            default: rx_pl_ready = 1'b0;
        endcase
    end

    assign pl_accept = rx_pl_valid && rx_pl_ready;
    assign pl_push   = pl_accept && (state == PASS);

    // Decision taken once per header, held until the last beat
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_accept) begin
                    state_next = port_match ? PASS : DROP;
                end
            end
            PASS, DROP: begin
                if (pl_accept && rx_pl_last) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Neither storage block is ever written while it reports full
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        !(hdr_push && hdr_full) && !(pl_push && pl_full)
    ) else $error("push into a full header queue or payload FIFO");

endmodule

/* design/reply_header_queue.sv */
`timescale 1ns/1ps

module reply_header_queue #(
    parameter int HDR_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,

    // Write side, fields taken from the received header
    input  logic                      hdr_push,
    output logic                      hdr_full,
    input  udp_fields_pkg::ip_addr_t  rx_src_ip,
    input  udp_fields_pkg::udp_port_t rx_src_port,
    input  udp_fields_pkg::udp_port_t rx_dst_port,
    input  udp_fields_pkg::udp_len_t  rx_length,

    // Reply header stream
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_fields_pkg::ip_addr_t  tx_dst_ip,
    output udp_fields_pkg::udp_port_t tx_src_port,
    output udp_fields_pkg::udp_port_t tx_dst_port,
    output udp_fields_pkg::udp_len_t  tx_length
);

    localparam int PTR_W = (HDR_DEPTH > 1) ? $clog2(HDR_DEPTH) : 1;
    localparam int CNT_W = $clog2(HDR_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(HDR_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(HDR_DEPTH);

    udp_fields_pkg::ip_addr_t  dst_ip_mem   [HDR_DEPTH];
    udp_fields_pkg::udp_port_t src_port_mem [HDR_DEPTH];
    udp_fields_pkg::udp_port_t dst_port_mem [HDR_DEPTH];
    udp_fields_pkg::udp_len_t  length_mem   [HDR_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign hdr_full     = (count == FULL_CNT);
    assign tx_hdr_valid = (count != '0);
    assign pop          = tx_hdr_valid && tx_hdr_ready;

    // Reply is built on entry, addresses and ports swapped
    always_ff @(posedge clk) begin
        if (hdr_push) begin
            dst_ip_mem[wr_ptr]   <= rx_src_ip;
            src_port_mem[wr_ptr] <= rx_dst_port;
            dst_port_mem[wr_ptr] <= rx_src_port;
            length_mem[wr_ptr]   <= rx_length;
        end
    end

    assign tx_dst_ip   = dst_ip_mem[rd_ptr];
    assign tx_src_port = src_port_mem[rd_ptr];
    assign tx_dst_port = dst_port_mem[rd_ptr];
    assign tx_length   = length_mem[rd_ptr];

    // Pointers wrap explicitly, depth need not be a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (hdr_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({hdr_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst) hdr_push |-> !hdr_full
    ) else $error("header pushed into a full queue");

endmodule

/* design/payload_fifo.sv */
`timescale 1ns/1ps

module payload_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                   clk,
    input  logic                   rst,

    // Write side, beat fields straight from the rx stream
    input  logic                   pl_push,
    output logic                   pl_full,
    input  stream_pkg::beat_data_t rx_pl_data,
    input  stream_pkg::beat_keep_t rx_pl_keep,
    input  logic                   rx_pl_last,
    input  logic                   rx_pl_user,

    // Echoed payload stream
    output logic                   tx_pl_valid,
    input  logic                   tx_pl_ready,
    output stream_pkg::beat_data_t tx_pl_data,
    output stream_pkg::beat_keep_t tx_pl_keep,
    output logic                   tx_pl_last,
    output logic                   tx_pl_user
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam logic [ADDR_W:0] FULL_CNT = (ADDR_W + 1)'(FIFO_DEPTH);

    // Pointer wrap relies on this
    if ((FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_depth_check
        $error("FIFO_DEPTH must be a power of two");
    end

    stream_pkg::beat_data_t data_mem [FIFO_DEPTH];
    stream_pkg::beat_keep_t keep_mem [FIFO_DEPTH];
    logic                   last_mem [FIFO_DEPTH];
    logic                   user_mem [FIFO_DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              pop;

    assign pl_full     = (count == FULL_CNT);
    assign tx_pl_valid = (count != '0);
    assign pop         = tx_pl_valid && tx_pl_ready;

    always_ff @(posedge clk) begin
        if (pl_push) begin
            data_mem[wr_ptr] <= rx_pl_data;
            keep_mem[wr_ptr] <= rx_pl_keep;
            last_mem[wr_ptr] <= rx_pl_last;
            user_mem[wr_ptr] <= rx_pl_user;
        end
    end

    // Head of queue presented without a read stage
    assign tx_pl_data = data_mem[rd_ptr];
    assign tx_pl_keep = keep_mem[rd_ptr];
    assign tx_pl_last = last_mem[rd_ptr];
    assign tx_pl_user = user_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pl_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({pl_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy bounded by depth across push and pop
    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= FULL_CNT
    ) else $error("payload FIFO count above depth");

endmodule

/* design/udp_echo_top.sv */
`timescale 1ns/1ps

// Fixed IP fields come from the IP stage downstream.
// TTL is udp_fields_pkg::REPLY_TTL, DSCP/ECN and checksum zero, local source IP
module udp_echo_top #(
    parameter udp_fields_pkg::udp_port_t ECHO_PORT = 16'd1234,
    parameter int HDR_DEPTH  = 4,
    parameter int FIFO_DEPTH = 64
) (
    input  logic                      clk,
    input  logic                      rst,

    // Parsed UDP header in
    input  logic                      rx_hdr_valid,
    output logic                      rx_hdr_ready,
    input  udp_fields_pkg::ip_addr_t  rx_src_ip,
    input  udp_fields_pkg::udp_port_t rx_src_port,
    input  udp_fields_pkg::udp_port_t rx_dst_port,
    input  udp_fields_pkg::udp_len_t  rx_length,

    // UDP payload in
    input  logic                      rx_pl_valid,
    output logic                      rx_pl_ready,
    input  stream_pkg::beat_data_t    rx_pl_data,
    input  stream_pkg::beat_keep_t    rx_pl_keep,
    input  logic                      rx_pl_last,
    input  logic                      rx_pl_user,

    // Reply header out
    output logic                      tx_hdr_valid,
    input  logic                      tx_hdr_ready,
    output udp_fields_pkg::ip_addr_t  tx_dst_ip,
    output udp_fields_pkg::udp_port_t tx_src_port,
    output udp_fields_pkg::udp_port_t tx_dst_port,
    output udp_fields_pkg::udp_len_t  tx_length,

    // Reply payload out
    output logic                      tx_pl_valid,
    input  logic                      tx_pl_ready,
    output stream_pkg::beat_data_t    tx_pl_data,
    output stream_pkg::beat_keep_t    tx_pl_keep,
    output logic                      tx_pl_last,
    output logic                      tx_pl_user,

    output stream_pkg::led_t          led
);

    logic hdr_push;
    logic hdr_full;
    logic pl_push;
    logic pl_full;
    logic frame_start;
    logic tx_pl_xfer;

    udp_echo_ctrl #(
        .ECHO_PORT(ECHO_PORT)
    ) i_udp_echo_ctrl (
        .clk         (clk),
        .rst         (rst),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_dst_port (rx_dst_port),
        .hdr_push    (hdr_push),
        .hdr_full    (hdr_full),
        .rx_pl_valid (rx_pl_valid),
        .rx_pl_ready (rx_pl_ready),
        .rx_pl_last  (rx_pl_last),
        .pl_push     (pl_push),
        .pl_full     (pl_full)
    );

    reply_header_queue #(
        .HDR_DEPTH(HDR_DEPTH)
    ) i_reply_header_queue (
        .clk         (clk),
        .rst         (rst),
        .hdr_push    (hdr_push),
        .hdr_full    (hdr_full),
        .rx_src_ip   (rx_src_ip),
        .rx_src_port (rx_src_port),
        .rx_dst_port (rx_dst_port),
        .rx_length   (rx_length),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_dst_ip   (tx_dst_ip),
        .tx_src_port (tx_src_port),
        .tx_dst_port (tx_dst_port),
        .tx_length   (tx_length)
    );

    payload_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_payload_fifo (
        .clk        (clk),
        .rst        (rst),
        .pl_push    (pl_push),
        .pl_full    (pl_full),
        .rx_pl_data (rx_pl_data),
        .rx_pl_keep (rx_pl_keep),
        .rx_pl_last (rx_pl_last),
        .rx_pl_user (rx_pl_user),
        .tx_pl_valid(tx_pl_valid),
        .tx_pl_ready(tx_pl_ready),
        .tx_pl_data (tx_pl_data),
        .tx_pl_keep (tx_pl_keep),
        .tx_pl_last (tx_pl_last),
        .tx_pl_user (tx_pl_user)
    );

    assign tx_pl_xfer = tx_pl_valid && tx_pl_ready;

    // First beat of each outgoing frame goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_start <= 1'b1;
            led         <= '0;
        end else if (tx_pl_xfer) begin
            frame_start <= tx_pl_last;
            if (frame_start) begin
                led <= tx_pl_data[2:0];
            end
        end
    end

endmodule

/* tests/udp_echo_tb.sv */
`timescale 1ns/1ps

module udp_echo_tb;

    localparam udp_fields_pkg::udp_port_t ECHO_PORT = 16'd1234;
    localparam int NUM_FRAMES = 16;
    localparam int TX_READY   = 0;
    localparam int TX_HOLD    = 1;
    localparam int TX_RANDOM  = 2;

    logic                      clk;
    logic                      rst;
    logic                      rx_hdr_valid;
    logic                      rx_hdr_ready;
    udp_fields_pkg::ip_addr_t  rx_src_ip;
    udp_fields_pkg::udp_port_t rx_src_port;
    udp_fields_pkg::udp_port_t rx_dst_port;
    udp_fields_pkg::udp_len_t  rx_length;
    logic                      rx_pl_valid;
    logic                      rx_pl_ready;
    stream_pkg::beat_data_t    rx_pl_data;
    stream_pkg::beat_keep_t    rx_pl_keep;
    logic                      rx_pl_last;
    logic                      rx_pl_user;
    logic                      tx_hdr_valid;
    logic                      tx_hdr_ready = 1'b1;
    udp_fields_pkg::ip_addr_t  tx_dst_ip;
    udp_fields_pkg::udp_port_t tx_src_port;
    udp_fields_pkg::udp_port_t tx_dst_port;
    udp_fields_pkg::udp_len_t  tx_length;
    logic                      tx_pl_valid;
    logic                      tx_pl_ready = 1'b1;
    stream_pkg::beat_data_t    tx_pl_data;
    stream_pkg::beat_keep_t    tx_pl_keep;
    logic                      tx_pl_last;
    logic                      tx_pl_user;
    stream_pkg::led_t          led;

    integer seed = 43;
    int tx_mode = TX_READY;
    int frame_len [NUM_FRAMES];
    int total_beats = 0;
    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;
    logic hdr_stall_seen = 1'b0;
    logic tx_first;
    stream_pkg::led_t exp_led;

    // Reply header as {dst_ip, src_port, dst_port, length}
    logic [79:0] exp_hdr [$];
    // Beat as {data, keep, last, user}
    logic [73:0] exp_beat [$];

    initial clk = 1'b0;
    always #4 clk = ~clk;

    udp_echo_top i_udp_echo_top (
        .clk         (clk),
        .rst         (rst),
        .rx_hdr_valid(rx_hdr_valid),
        .rx_hdr_ready(rx_hdr_ready),
        .rx_src_ip   (rx_src_ip),
        .rx_src_port (rx_src_port),
        .rx_dst_port (rx_dst_port),
        .rx_length   (rx_length),
        .rx_pl_valid (rx_pl_valid),
        .rx_pl_ready (rx_pl_ready),
        .rx_pl_data  (rx_pl_data),
        .rx_pl_keep  (rx_pl_keep),
        .rx_pl_last  (rx_pl_last),
        .rx_pl_user  (rx_pl_user),
        .tx_hdr_valid(tx_hdr_valid),
        .tx_hdr_ready(tx_hdr_ready),
        .tx_dst_ip   (tx_dst_ip),
        .tx_src_port (tx_src_port),
        .tx_dst_port (tx_dst_port),
        .tx_length   (tx_length),
        .tx_pl_valid (tx_pl_valid),
        .tx_pl_ready (tx_pl_ready),
        .tx_pl_data  (tx_pl_data),
        .tx_pl_keep  (tx_pl_keep),
        .tx_pl_last  (tx_pl_last),
        .tx_pl_user  (tx_pl_user),
        .led         (led)
    );

    // LED tracks byte 0 of the first beat of each echoed frame
    a_led_value: assert property (@(posedge clk) disable iff (rst) led == exp_led)
    else begin
        $display("[ERROR] led expected 0x%0h got 0x%0h", $sampled(exp_led), $sampled(led));
        errors++;
    end

    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid
            && $stable({tx_dst_ip, tx_src_port, tx_dst_port, tx_length}))
    else begin
        $display("Reply header dropped or changed while stalled");
        errors++;
    end

    a_pl_hold: assert property (@(posedge clk) disable iff (rst)
        tx_pl_valid && !tx_pl_ready |=> tx_pl_valid
            && $stable({tx_pl_data, tx_pl_keep, tx_pl_last, tx_pl_user}))
    else begin
        $display("Payload beat dropped or changed while stalled");
        errors++;
    end

    task automatic check_hex(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    // Tx ready patterns
    always @(negedge clk) begin
        case (tx_mode)
            TX_HOLD: begin
                tx_hdr_ready = 1'b0;
                tx_pl_ready  = 1'b0;
            end
            TX_RANDOM: begin
                tx_hdr_ready = ($random(seed) & 3) != 0;
                tx_pl_ready  = ($random(seed) & 1) != 0;
            end
            default: begin
                tx_hdr_ready = 1'b1;
                tx_pl_ready  = 1'b1;
            end
        endcase
    end

    always @(posedge clk) begin : scoreboard
        logic [79:0] h;
        logic [73:0] b;
        if (rst) begin
            tx_first = 1'b1;
            exp_led <= '0;
        end else begin
            if (rx_hdr_valid && !rx_hdr_ready) begin
                hdr_stall_seen = 1'b1;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr.size() == 0) begin
                    $display("Reply header sent where no echo was expected");
                    errors++;
                end else begin
                    h = exp_hdr.pop_front();
                    check_hex("tx_dst_ip", h[79:48], tx_dst_ip);
                    check_hex("tx_src_port", h[47:32], tx_src_port);
                    check_hex("tx_dst_port", h[31:16], tx_dst_port);
                    check_hex("tx_length", h[15:0], tx_length);
                end
            end
            if (tx_pl_valid && tx_pl_ready) begin
                if (exp_beat.size() == 0) begin
                    $display("Payload beat sent where no echo was expected");
                    errors++;
                end else begin
                    b = exp_beat.pop_front();
                    check_hex("tx_pl_data", b[73:10], tx_pl_data);
                    check_hex("tx_pl_keep", b[9:2], tx_pl_keep);
                    check_hex("tx_pl_last", b[1], tx_pl_last);
                    check_hex("tx_pl_user", b[0], tx_pl_user);
                    if (tx_first) begin
                        exp_led <= b[12:10];
                    end
                    tx_first = b[1];
                end
            end
        end
    end

    task automatic send_frame(input int n, input udp_fields_pkg::udp_port_t dst_port);
        stream_pkg::beat_data_t    data_buf [10];
        stream_pkg::beat_keep_t    keep_buf [10];
        logic                      user_buf [10];
        udp_fields_pkg::ip_addr_t  src_ip;
        udp_fields_pkg::udp_port_t src_port;
        udp_fields_pkg::udp_len_t  length;
        int last_bytes;
        src_ip     = $random(seed);
        src_port   = 16'($random(seed));
        last_bytes = ($random(seed) & 7) + 1;
        for (int i = 0; i < n; i++) begin
            data_buf[i] = {$random(seed), $random(seed)};
            keep_buf[i] = (i == n - 1) ? 8'((1 << last_bytes) - 1) : 8'hFF;
            user_buf[i] = 1'($random(seed));
        end
        // UDP length counts the 8-byte header
        length = 16'(8 + 8 * (n - 1) + last_bytes);
        if (dst_port == ECHO_PORT) begin
            exp_hdr.push_back({src_ip, ECHO_PORT, src_port, length});
            for (int i = 0; i < n; i++) begin
                exp_beat.push_back({data_buf[i], keep_buf[i], i == n - 1, user_buf[i]});
            end
        end
        @(negedge clk);
        rx_pl_valid  = 1'b0;
        rx_hdr_valid = 1'b1;
        rx_src_ip    = src_ip;
        rx_src_port  = src_port;
        rx_dst_port  = dst_port;
        rx_length    = length;
        @(posedge clk);
        while (!rx_hdr_ready) begin
            @(posedge clk);
        end
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            rx_hdr_valid = 1'b0;
            rx_pl_valid  = 1'b1;
            rx_pl_data   = data_buf[i];
            rx_pl_keep   = keep_buf[i];
            rx_pl_last   = (i == n - 1);
            rx_pl_user   = user_buf[i];
            @(posedge clk);
            while (!rx_pl_ready) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic idle_inputs();
        @(negedge clk);
        rx_hdr_valid = 1'b0;
        rx_pl_valid  = 1'b0;
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_hdr.size() != 0 || exp_beat.size() != 0) && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_hdr.size() != 0 || exp_beat.size() != 0) begin
            $display("Echoed frames still missing after %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s (%0d errors)", name, errors - errors_before);
        end
    endtask

    initial begin : watchdog
        wait (total_beats != 0);
        repeat (total_beats * 20 + 1000) @(posedge clk);
        $display("Watchdog expired after %0d cycles", total_beats * 20 + 1000);
        $display("Simulation failed");
        $finish;
    end

    initial begin : main
        int err_start;
        int sum;
        int n;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_length    = '0;
        rx_pl_valid  = 1'b0;
        rx_pl_data   = '0;
        rx_pl_keep   = '0;
        rx_pl_last   = 1'b0;
        rx_pl_user   = 1'b0;
        // Frame lengths fixed up front so the run length is known
        frame_len[0] = 3;
        frame_len[1] = 2;
        frame_len[2] = 4;
        frame_len[3] = 1;
        frame_len[4] = 2;
        for (int i = 5; i < 13; i++) begin
            frame_len[i] = {$random(seed)} % 10 + 1;
        end
        frame_len[13] = 1;
        frame_len[14] = 3;
        frame_len[15] = 2;
        sum = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            sum += frame_len[i];
        end
        total_beats = sum;
        $display("UDP echo on port %0d, reply TTL %0d", ECHO_PORT, udp_fields_pkg::REPLY_TTL);

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        err_start = errors;
        repeat (3) @(negedge clk);
        check_hex("tx_hdr_valid", 0, tx_hdr_valid);
        check_hex("tx_pl_valid", 0, tx_pl_valid);
        check_hex("led", 0, led);
        check_hex("rx_hdr_ready", 1, rx_hdr_ready);
        check_hex("rx_pl_ready", 0, rx_pl_ready);
        finish_test("reset state", err_start);

        err_start = errors;
        send_frame(frame_len[0], ECHO_PORT);
        idle_inputs();
        wait_drained(1000);
        finish_test("echo of a matching frame", err_start);

        err_start = errors;
        send_frame(frame_len[1], 16'd1235);
        send_frame(frame_len[2], 16'd80);
        send_frame(frame_len[3], 16'd1233);
        idle_inputs();
        repeat (10) @(negedge clk);
        check_hex("tx_hdr_valid", 0, tx_hdr_valid);
        check_hex("tx_pl_valid", 0, tx_pl_valid);
        send_frame(frame_len[4], ECHO_PORT);
        idle_inputs();
        wait_drained(1000);
        finish_test("drop of non-matching frames", err_start);

        // Hold tx until the header queue fills, then release into random stalls
        err_start = errors;
        hdr_stall_seen = 1'b0;
        tx_mode = TX_HOLD;
        fork
            begin
                for (int f = 5; f < 13; f++) begin
                    send_frame(frame_len[f], ECHO_PORT);
                end
            end
            begin
                n = 0;
                while (!hdr_stall_seen && n < 200) begin
                    @(posedge clk);
                    n++;
                end
                repeat (20) @(posedge clk);
                tx_mode = TX_RANDOM;
            end
        join
        idle_inputs();
        wait_drained(2000);
        tx_mode = TX_READY;
        if (!hdr_stall_seen) begin
            $display("rx_hdr_ready was never low while tx was stalled");
            errors++;
        end
        finish_test("back-pressure", err_start);

        err_start = errors;
        tx_mode = TX_RANDOM;
        for (int f = 13; f < NUM_FRAMES; f++) begin
            send_frame(frame_len[f], ECHO_PORT);
        end
        idle_inputs();
        wait_drained(1000);
        tx_mode = TX_READY;
        finish_test("led from first beat", err_start);

        repeat (5) @(posedge clk);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim.f */
design/udp_fields_pkg.sv
design/stream_pkg.sv
design/udp_echo_ctrl.sv
design/reply_header_queue.sv
design/payload_fifo.sv
design/udp_echo_top.sv
tests/udp_echo_tb.sv

/* Bender.yml */
package:
  name: udp_echo

sources:
  # Packages first, then the RTL bottom up
  - files:
      - design/udp_fields_pkg.sv
      - design/stream_pkg.sv
      - design/udp_echo_ctrl.sv
      - design/reply_header_queue.sv
      - design/payload_fifo.sv
      - design/udp_echo_top.sv

  # Testbench, top module udp_echo_tb
  - target: test
    files:
      - tests/udp_echo_tb.sv
